/* dpi_stream_pkg.sv */
package dpi_stream_pkg;

  // Number of interleaved byte streams
  localparam int NUM_STREAMS = 64;

  // Stream number width
  localparam int STREAM_ID_W = 6;

  // One payload byte per beat
  localparam int CHAR_W = 8;

  // Beats held between ingress and matcher
  localparam int FIFO_DEPTH = 8;

  // Match counter width, wraps on overflow
  localparam int COUNT_W = 16;

  // Progress through the keyword "HELO"
  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_H    = 2'd1,
    S_HE   = 2'd2,
    S_HEL  = 2'd3
  } dfa_state_t;

  // One byte of a packet with its stream and boundary flags
  typedef struct packed {
    logic [CHAR_W-1:0]      data;
    logic [STREAM_ID_W-1:0] stream_id;
    logic                   sop;
    logic                   eop;
    // Set by ingress on the first packet of an unseen stream
    logic                   new_stream;
  } beat_t;

endpackage

/* dpi_regs_pkg.sv */
package dpi_regs_pkg;

  // APB address and data widths
  localparam int APB_ADDR_W = 4;
  localparam int APB_DATA_W = 32;

  // Register offsets
  typedef enum logic [APB_ADDR_W-1:0] {
    // Enable bits for streams 0 to 31
    REG_ENABLE_LO = 4'h0,
    // Enable bits for streams 32 to 63
    REG_ENABLE_HI = 4'h4,
    // Match counter, read only
    REG_COUNT     = 4'h8,
    // Forget all streams, write only strobe
    REG_FORGET    = 4'hC
  } reg_addr_t;

  // Requester side of the APB bus
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

endpackage

/* helo_dfa.sv */
`timescale 1ns/1ps

module helo_dfa
  import dpi_stream_pkg::*;
(
  input  dfa_state_t        state_in,
  input  logic [CHAR_W-1:0] char_in,
  output dfa_state_t        state_out,
  output logic              accept
);

  // Keyword bytes in ASCII
  logic is_h;
  logic is_e;
  logic is_l;
  logic is_o;

  assign is_h = (char_in == 8'h48);
  assign is_e = (char_in == 8'h45);
  assign is_l = (char_in == 8'h4C);
  assign is_o = (char_in == 8'h4F);

  always_comb
  begin
    accept = 1'b0;
    // A stray 'H' always restarts the keyword
    state_out = is_h ? S_H : S_IDLE;
    case (state_in)
      S_H:
        if (is_e)
          state_out = S_HE;
      S_HE:
        if (is_l)
          state_out = S_HEL;
      S_HEL:
        if (is_o)
        begin
          // Full keyword seen
          accept    = 1'b1;
          state_out = S_IDLE;
        end
      default: ;
    endcase
  end

endmodule

/* apb_cfg_regs.sv */
`timescale 1ns/1ps

module apb_cfg_regs
  import dpi_stream_pkg::*;
  import dpi_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  apb_req_t               apb_req,
  input  logic [COUNT_W-1:0]     match_count,
  output logic [APB_DATA_W-1:0]  prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic [NUM_STREAMS-1:0] stream_enable,
  output logic                   forget
);

  // Enable mask halves
  logic [APB_DATA_W-1:0] enable_lo;
  logic [APB_DATA_W-1:0] enable_hi;

  // ACCESS phase qualifiers
  logic      access;
  logic      wr_en;
  logic      rd_en;
  reg_addr_t addr;

  assign addr   = reg_addr_t'(apb_req.paddr);
  assign access = apb_req.psel & apb_req.penable;
  assign wr_en  = access & apb_req.pwrite;
  assign rd_en  = access & ~apb_req.pwrite;

  // No wait states
  assign pready = 1'b1;

  // Reading the strobe or writing the counter is an error
  assign pslverr = (rd_en && (addr == REG_FORGET)) || (wr_en && (addr == REG_COUNT));

  assign stream_enable = {enable_hi, enable_lo};

  // Write decode, takes effect at the ACCESS edge
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      enable_lo <= '0;
      enable_hi <= '0;
      forget    <= 1'b0;
    end
    else
    begin
      // One cycle pulse per write to the strobe
      forget <= wr_en && (addr == REG_FORGET);
      if (wr_en)
      begin
        case (addr)
          REG_ENABLE_LO: enable_lo <= apb_req.pwdata;
          REG_ENABLE_HI: enable_hi <= apb_req.pwdata;
          default:       ;
        endcase
      end
    end
  end

  // Read mux
  always_comb
  begin
    prdata = '0;
    if (rd_en)
    begin
      case (addr)
        REG_ENABLE_LO: prdata = enable_lo;
        REG_ENABLE_HI: prdata = enable_hi;
        // Counter zero extended to the bus
        REG_COUNT:     prdata = {{(APB_DATA_W-COUNT_W){1'b0}}, match_count};
        default:       prdata = '0;
      endcase
    end
  end

  // ACCESS phase is always entered from SETUP with psel held
  a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(apb_req.penable) |-> apb_req.psel);

endmodule

/* pkt_ingress.sv */
`timescale 1ns/1ps

module pkt_ingress
  import dpi_stream_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  beat_t in_beat,
  input  logic  forget,
  input  logic  full,
  output logic  in_ready,
  output logic  push,
  output beat_t push_beat
);

  // Streams that started a packet since reset or the last forget
  logic [NUM_STREAMS-1:0] seen;
  logic [NUM_STREAMS-1:0] seen_next;

  // Byte transfer on this edge
  logic accept;

  // Ready follows FIFO space directly
  assign in_ready = ~full;
  assign accept   = in_valid & in_ready;
  assign push     = accept;

  // Tag the beat
  always_comb
  begin
    push_beat = in_beat;
    // Forget in the same cycle makes every stream look unseen
    push_beat.new_stream = in_beat.sop & (forget | ~seen[in_beat.stream_id]);
  end

  // Bitmap update
  always_comb
  begin
    seen_next = forget ? '0 : seen;
    if (accept && in_beat.sop)
    begin
      seen_next[in_beat.stream_id] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen <= '0;
    end
    else
    begin
      seen <= seen_next;
    end
  end

endmodule

/* beat_fifo.sv */
`timescale 1ns/1ps

module beat_fifo
  import dpi_stream_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  push,
  input  beat_t push_beat,
  input  logic  pop,
  output logic  full,
  output logic  pop_valid,
  output beat_t pop_beat
);

  // Entry storage
  beat_t mem [FIFO_DEPTH];

  // Pointers wrap naturally at a power of two depth
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count;

  // Qualified transfers
  logic do_push;
  logic do_pop;

  assign full      = (count == FIFO_DEPTH);
  assign pop_valid = (count != 0);
  assign do_push   = push & ~full;
  assign do_pop    = pop & pop_valid;

  // Head entry shown directly
  assign pop_beat = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_beat;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      // Occupancy holds when both happen
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Ingress must stall on full
  a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full);

endmodule

/* stream_matcher.sv */
`timescale 1ns/1ps

module stream_matcher
  import dpi_stream_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pop_valid,
  input  beat_t                  pop_beat,
  input  logic [NUM_STREAMS-1:0] stream_enable,
  output logic                   pop,
  output logic [COUNT_W-1:0]     match_count
);

  // Saved DFA state per stream
  dfa_state_t state_mem [NUM_STREAMS];

  // Streams whose memory entry holds a saved state
  logic [NUM_STREAMS-1:0] saved;
  // Streams with a packet between sop and eop
  logic [NUM_STREAMS-1:0] open_pkt;

  // State of the packet in progress
  dfa_state_t cur_state;
  logic       pkt_match;

  // DFA hookup
  dfa_state_t start_state;
  dfa_state_t next_state;
  logic       accept;

  // Per beat decisions
  logic hit;
  logic enabled;
  logic do_save;

  // Always ready for the next beat
  assign pop = pop_valid;

  assign enabled = stream_enable[pop_beat.stream_id];

  // Restore at sop, fresh start for an unseen or never saved stream
  always_comb
  begin
    if (!pop_beat.sop)
      start_state = cur_state;
    else if (pop_beat.new_stream || !saved[pop_beat.stream_id])
      start_state = S_IDLE;
    else
      start_state = state_mem[pop_beat.stream_id];
  end

  helo_dfa u_dfa (
    .state_in  (start_state),
    .char_in   (pop_beat.data),
    .state_out (next_state),
    .accept    (accept)
  );

  // Packet flag restarts at sop
  assign hit     = (pop_beat.sop ? 1'b0 : pkt_match) | accept;
  assign do_save = pop_valid & pop_beat.eop & enabled;

  always_ff @(posedge clk)
  begin
    if (do_save)
      state_mem[pop_beat.stream_id] <= next_state;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cur_state   <= S_IDLE;
      pkt_match   <= 1'b0;
      match_count <= '0;
      saved       <= '0;
      open_pkt    <= '0;
    end
    else if (pop_valid)
    begin
      cur_state <= next_state;
      pkt_match <= hit;
      // Old history is dropped for a new stream
      if (pop_beat.sop && pop_beat.new_stream)
        saved[pop_beat.stream_id] <= 1'b0;
      if (do_save)
      begin
        saved[pop_beat.stream_id] <= 1'b1;
        // At most one count per packet, wraps
        match_count <= match_count + COUNT_W'(hit);
      end
      open_pkt[pop_beat.stream_id] <= ~pop_beat.eop;
    end
  end

  // Packets of one stream never overlap
  a_no_reopen: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && pop_beat.sop |-> !open_pkt[pop_beat.stream_id]);

endmodule

/* dpi_top.sv */
`timescale 1ns/1ps

module dpi_top
  import dpi_stream_pkg::*;
  import dpi_regs_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  beat_t                 in_beat,
  input  apb_req_t              apb_req,
  output logic                  in_ready,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr
);

  // Ingress to FIFO
  logic  push;
  beat_t push_beat;
  logic  full;

  // FIFO to matcher
  logic  pop;
  logic  pop_valid;
  beat_t pop_beat;

  // Configuration and status
  logic [NUM_STREAMS-1:0] stream_enable;
  logic                   forget;
  logic [COUNT_W-1:0]     match_count;

  apb_cfg_regs u_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .apb_req       (apb_req),
    .match_count   (match_count),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .stream_enable (stream_enable),
    .forget        (forget)
  );

  pkt_ingress u_ingress (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .forget    (forget),
    .full      (full),
    .in_ready  (in_ready),
    .push      (push),
    .push_beat (push_beat)
  );

  beat_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_beat (push_beat),
    .pop       (pop),
    .full      (full),
    .pop_valid (pop_valid),
    .pop_beat  (pop_beat)
  );

  stream_matcher u_matcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .pop_valid     (pop_valid),
    .pop_beat      (pop_beat),
    .stream_enable (stream_enable),
    .pop           (pop),
    .match_count   (match_count)
  );

endmodule

/* dpi_tb_tasks.svh */
// One APB transfer as SETUP then ACCESS until pready
task automatic apb_access(input bit write, input logic [APB_ADDR_W-1:0] addr,
                          input logic [APB_DATA_W-1:0] wdata,
                          output logic [APB_DATA_W-1:0] rdata, output bit err);
  bit done;
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;
  apb_req.pwrite  = write;
  apb_req.paddr   = addr;
  apb_req.pwdata  = wdata;
  @(posedge clk);
  #1;
  apb_req.penable = 1'b1;
  done = 1'b0;
  while (!done)
  begin
    // Slave outputs sampled mid cycle
    #4;
    done  = pready;
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
  end
  apb_req = '0;
endtask

task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                         input logic [APB_DATA_W-1:0] wdata, output bit err);
  logic [APB_DATA_W-1:0] unused;
  apb_access(1'b1, addr, wdata, unused, err);
endtask

task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                        output logic [APB_DATA_W-1:0] rdata, output bit err);
  apb_access(1'b0, addr, '0, rdata, err);
endtask

// Drive pkt_buf on stream sid
// Bit i of gaps idles one cycle before byte i
task automatic send_buf(input int sid, input int gaps);
  bit accepted;
  int i;
  model_packet(sid);
  for (i = 0; i < pkt_len; i++)
  begin
    if (gaps[i % 32])
    begin
      in_valid = 1'b0;
      @(posedge clk);
      #1;
    end
    in_valid             = 1'b1;
    in_beat.data         = pkt_buf[i];
    in_beat.stream_id    = sid[STREAM_ID_W-1:0];
    in_beat.sop          = (i == 0);
    in_beat.eop          = (i == pkt_len - 1);
    in_beat.new_stream   = 1'b0;
    // Beat held until an edge with in_ready high
    do
    begin
      accepted = in_ready;
      @(posedge clk);
      #1;
    end while (!accepted);
  end
  in_valid = 1'b0;
endtask

task automatic send_packet(input string s, input int sid, input int gaps);
  int i;
  pkt_len = s.len();
  for (i = 0; i < pkt_len; i++)
    pkt_buf[i] = s[i];
  send_buf(sid, gaps);
endtask

// Idle time for the FIFO and matcher to empty
task automatic drain();
  repeat (20) @(posedge clk);
  #1;
endtask

task automatic set_enable(input logic [NUM_STREAMS-1:0] mask);
  bit err_lo;
  bit err_hi;
  apb_write(REG_ENABLE_LO, mask[31:0], err_lo);
  apb_write(REG_ENABLE_HI, mask[63:32], err_hi);
  model_enable = mask;
  if (err_lo || err_hi)
  begin
    $display("ERR %0t: pslverr expected 0 got 1 on enable write", $time);
    test_ok = 1'b0;
  end
endtask

task automatic check_count();
  logic [APB_DATA_W-1:0] rdata;
  bit                    err;
  apb_read(REG_COUNT, rdata, err);
  if (err)
  begin
    $display("ERR %0t: pslverr expected 0 got 1 on count read", $time);
    test_ok = 1'b0;
  end
  if (rdata !== {{(APB_DATA_W-COUNT_W){1'b0}}, exp_count})
  begin
    $display("ERR %0t: match count expected %0d got %0d", $time, exp_count, rdata);
    test_ok = 1'b0;
  end
endtask

task automatic report_test(input string name);
  if (test_ok)
  begin
    pass_count++;
    $display("%0t %s: ok", $time, name);
  end
  else
  begin
    fail_count++;
    $display("%0t %s: failed", $time, name);
  end
endtask

task automatic test_single_match();
  logic [APB_DATA_W-1:0] rdata;
  bit                    err;
  test_ok = 1'b1;
  set_enable(64'h1 << 3);
  send_packet("xHELOy", 3, 0);
  drain();
  check_count();
  // Count is read only and forget is write only
  apb_write(REG_COUNT, 32'h1234, err);
  if (!err)
  begin
    $display("ERR %0t: pslverr expected 1 got 0 on count write", $time);
    test_ok = 1'b0;
  end
  apb_read(REG_FORGET, rdata, err);
  if (!err)
  begin
    $display("ERR %0t: pslverr expected 1 got 0 on forget read", $time);
    test_ok = 1'b0;
  end
  check_count();
  report_test("single match on stream 3");
endtask

task automatic test_disabled_stream();
  test_ok = 1'b1;
  send_packet("HELO", 5, 0);
  // Partial keyword that a disabled stream must not keep
  send_packet("HE", 5, 0);
  drain();
  check_count();
  // Nothing was saved while disabled
  set_enable(model_enable | (64'h1 << 5));
  send_packet("LO", 5, 32'h2);
  drain();
  check_count();
  report_test("disabled stream 5");
endtask

task automatic test_split_keyword();
  test_ok = 1'b1;
  set_enable(model_enable | (64'h1 << 7) | (64'h1 << 9));
  send_packet("HE", 7, 0);
  send_packet("zz", 9, 32'h1);
  send_packet("LO", 7, 0);
  drain();
  check_count();
  report_test("keyword split across packets");
endtask

task automatic test_forget();
  bit err;
  test_ok = 1'b1;
  send_packet("HEL", 7, 0);
  drain();
  apb_write(REG_FORGET, 32'h1, err);
  forget_model();
  if (err)
  begin
    $display("ERR %0t: pslverr expected 0 got 1 on forget write", $time);
    test_ok = 1'b0;
  end
  send_packet("O", 7, 0);
  drain();
  check_count();
  report_test("forget clears history");
endtask

task automatic test_back_to_back();
  string word;
  int    i;
  test_ok = 1'b1;
  word = "HELO";
  set_enable(model_enable | (64'h1 << 11) | (64'h1 << 12));
  send_packet("HELOHELO", 11, 0);
  // Single byte packets with stream 13 disabled in between
  for (i = 0; i < 12; i++)
  begin
    pkt_len    = 1;
    pkt_buf[0] = word[i % 4];
    send_buf(12, 0);
    pkt_buf[0] = "H";
    send_buf(13, 0);
  end
  drain();
  check_count();
  report_test("repeated keyword and single byte packets");
endtask

task automatic test_random_packets();
  logic [NUM_STREAMS-1:0] mask;
  int unsigned            r;
  string                  alphabet;
  int                     sid;
  int                     gaps;
  int                     p;
  int                     i;
  test_ok  = 1'b1;
  alphabet = "HELOx";
  for (p = 0; p < 40; p++)
  begin
    // New enables for streams 16 to 23 only with the pipe empty
    if (p % 10 == 0)
    begin
      drain();
      r = $random(seed);
      mask = model_enable;
      mask[23:16] = r[7:0];
      set_enable(mask);
    end
    r = $random(seed);
    sid     = 16 + r[2:0];
    pkt_len = 1 + r[5:3];
    for (i = 0; i < pkt_len; i++)
    begin
      r = $random(seed);
      pkt_buf[i] = alphabet[r[15:0] % 5];
    end
    // Sparse idle cycles
    gaps = $random(seed) & $random(seed);
    send_buf(sid, gaps);
  end
  drain();
  check_count();
  report_test("random packets over 8 streams");
endtask

/* dpi_tb.sv */
`timescale 1ns/1ps

module dpi_tb
  import dpi_stream_pkg::*;
  import dpi_regs_pkg::*;
();

  // Budget of 200 cycles per test plus the random run
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = 200 * NUM_TESTS + 2000;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  beat_t                 in_beat;
  apb_req_t              apb_req;
  logic                  in_ready;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  // Reference model, keyword progress 0 to 3 per stream
  int                     model_state [NUM_STREAMS];
  bit                     model_saved [NUM_STREAMS];
  bit                     model_seen  [NUM_STREAMS];
  logic [NUM_STREAMS-1:0] model_enable;
  logic [COUNT_W-1:0]     exp_count;

  // Bytes of the next packet to send
  byte pkt_buf [64];
  int  pkt_len;

  integer seed;
  bit     test_ok;
  int     pass_count;
  int     fail_count;

  dpi_top DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_beat  (in_beat),
    .apb_req  (apb_req),
    .in_ready (in_ready),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

  // Keyword progress: 0 nothing, 1 H, 2 HE, 3 HEL
  function automatic int keyword_step(input int st, input byte ch);
    if (st == 1 && ch == "E")
      return 2;
    if (st == 2 && ch == "L")
      return 3;
    // Any H restarts, everything else drops back
    if (ch == "H")
      return 1;
    return 0;
  endfunction

  // Expected effect of the packet in pkt_buf on stream sid
  task automatic model_packet(input int sid);
    int st;
    bit hit;
    int i;
    // First packet since reset or forget starts clean
    if (!model_seen[sid])
    begin
      model_seen[sid]  = 1'b1;
      model_saved[sid] = 1'b0;
    end
    st  = model_saved[sid] ? model_state[sid] : 0;
    hit = 1'b0;
    for (i = 0; i < pkt_len; i++)
    begin
      if (st == 3 && pkt_buf[i] == "O")
        hit = 1'b1;
      st = keyword_step(st, pkt_buf[i]);
    end
    // Only enabled streams count and keep history
    if (model_enable[sid])
    begin
      if (hit)
        exp_count = exp_count + 1'b1;
      model_state[sid] = st;
      model_saved[sid] = 1'b1;
    end
  endtask

  task automatic forget_model();
    int i;
    for (i = 0; i < NUM_STREAMS; i++)
      model_seen[i] = 1'b0;
  endtask

  `include "dpi_tb_tasks.svh"

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the test sequence did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_beat      = '0;
    apb_req      = '0;
    seed         = 69;
    pass_count   = 0;
    fail_count   = 0;
    exp_count    = '0;
    model_enable = '0;
    pkt_len      = 0;
    for (int i = 0; i < NUM_STREAMS; i++)
    begin
      model_state[i] = 0;
      model_saved[i] = 1'b0;
      model_seen[i]  = 1'b0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_single_match();
    test_disabled_stream();
    test_split_keyword();
    test_forget();
    test_back_to_back();
    test_random_packets();

    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* build.f */
dpi_stream_pkg.sv
dpi_regs_pkg.sv
helo_dfa.sv
apb_cfg_regs.sv
pkt_ingress.sv
beat_fifo.sv
stream_matcher.sv
dpi_top.sv
+incdir+.
dpi_tb.sv
